/* logic/icache_pkg.sv */
package icache_pkg;

	localparam int ADDR_W = 32; // one word
	localparam int WAYS = 4;

	typedef logic [ADDR_W-1:0] word_t;
	typedef logic [1:0] way_idx_t;
	typedef logic [WAYS-1:0] way_mask_t;

	// [2] root, [1] leaf of ways 0/1, [0] leaf of ways 2/3
	typedef logic [2:0] plru_t;

	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		REQUEST,
		RECEIVING,
		REFILL
	} refill_state_t;

	typedef struct packed {
		logic valid;
		word_t line_addr; // word address, offset bits zero
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic last;
		word_t data;
	} mem_resp_t;

endpackage

/* logic/icache_tag_ram.sv */
`timescale 1ns/1ps

module icache_tag_ram #(
	parameter int LINE_WORDS = 8,
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = icache_pkg::ADDR_W - IDX_W - $clog2(LINE_WORDS)
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_wen,
	input  logic [IDX_W-1:0] i_waddr,
	input  logic i_wvalid,
	input  logic [TAG_W-1:0] i_wtag,
	input  logic [IDX_W-1:0] i_raddr,
	output logic o_rvalid,
	output logic [TAG_W-1:0] o_rtag
);

	logic valid_mem [SETS];
	logic [TAG_W-1:0] tag_mem [SETS];
	logic bypass;

	assign bypass = i_wen && i_waddr == i_raddr; // write wins over read of same set

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			valid_mem[i_waddr] <= i_wvalid;
			tag_mem[i_waddr] <= i_wtag;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= bypass ? i_wvalid : valid_mem[i_raddr];
		end
	end

	always_ff @(posedge i_clk) begin
		o_rtag <= bypass ? i_wtag : tag_mem[i_raddr];
	end

endmodule

/* logic/icache_data_ram.sv */
`timescale 1ns/1ps

module icache_data_ram #(
	parameter int LINE_WORDS = 8,
	parameter int SETS = 64,
	localparam int ADR_W = $clog2(SETS) + $clog2(LINE_WORDS)
) (
	input  logic i_clk,
	input  logic i_wen,
	input  logic [ADR_W-1:0] i_waddr,
	input  icache_pkg::word_t i_wdata,
	input  logic [ADR_W-1:0] i_raddr,
	output icache_pkg::word_t o_rdata
);
	import icache_pkg::*;

	// {set, word offset}
	word_t mem [SETS*LINE_WORDS];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	always_ff @(posedge i_clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

/* logic/icache_plru.sv */
`timescale 1ns/1ps

module icache_plru #(
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS)
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic [IDX_W-1:0] i_set,
	input  logic i_touch,
	input  icache_pkg::way_idx_t i_touch_way,
	output icache_pkg::way_idx_t o_victim
);
	import icache_pkg::*;

	plru_t lru_q [SETS];
	plru_t cur;
	plru_t nxt;

	assign cur = lru_q[i_set];

	// root picks the half, then that half's leaf picks the way
	always_comb begin
		if (cur[2]) begin
			o_victim = {1'b1, cur[0]};
		end else begin
			o_victim = {1'b0, cur[1]};
		end
	end

	// point away from the touched way
	always_comb begin
		nxt = cur;
		nxt[2] = ~i_touch_way[1];
		if (i_touch_way[1]) begin
			nxt[0] = ~i_touch_way[0];
		end else begin
			nxt[1] = ~i_touch_way[0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < SETS; s++) begin
				lru_q[s] <= '0;
			end
		end else if (i_touch) begin
			lru_q[i_set] <= nxt;
		end
	end

endmodule

/* logic/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill #(
	parameter int LINE_WORDS = 8,
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int TAG_W = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_miss,
	input  icache_pkg::word_t i_miss_addr,
	input  icache_pkg::way_idx_t i_victim,
	input  logic i_inval,
	input  icache_pkg::word_t i_inval_addr,
	input  icache_pkg::mem_resp_t i_mem_resp,
	output logic o_busy,
	output icache_pkg::mem_req_t o_mem_req,
	output icache_pkg::way_mask_t o_tag_wen,
	output logic [IDX_W-1:0] o_tag_waddr,
	output logic o_tag_wvalid,
	output logic [TAG_W-1:0] o_tag_wtag,
	output icache_pkg::way_mask_t o_data_wen,
	output logic [IDX_W+OFF_W-1:0] o_data_waddr,
	output logic o_fwd_valid,
	output icache_pkg::word_t o_fwd_data
);
	import icache_pkg::*;

	refill_state_t state_q;
	refill_state_t state_d;
	logic [IDX_W-1:0] sweep_cnt;
	logic [OFF_W-1:0] word_cnt;
	word_t miss_addr;
	way_mask_t victim_mask;
	logic [IDX_W-1:0] miss_set;
	logic inval_take;
	logic inval_q;
	logic [IDX_W-1:0] inval_set;
	logic word_in;

	assign miss_set = miss_addr[OFF_W +: IDX_W];
	assign word_in = state_q == RECEIVING && i_mem_resp.valid;
	assign inval_take = i_inval && state_q == IDLE && !i_miss; // ignored while stalled

	always_comb begin
		state_d = state_q;
		case (state_q)
			INVALIDATING: begin
				if (sweep_cnt == IDX_W'(SETS - 1)) begin
					state_d = IDLE;
				end
			end
			IDLE: begin
				if (i_miss) begin
					state_d = REQUEST;
				end
			end
			REQUEST: state_d = RECEIVING;
			RECEIVING: begin
				if (word_in && i_mem_resp.last) begin
					state_d = REFILL;
				end
			end
			REFILL: state_d = IDLE;
			default: state_d = INVALIDATING;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= INVALIDATING;
			sweep_cnt <= '0;
			word_cnt <= '0;
			inval_q <= 1'b0;
		end else begin
			state_q <= state_d;
			inval_q <= inval_take;
			if (state_q == INVALIDATING) begin
				sweep_cnt <= sweep_cnt + 1'b1;
			end
			if (state_q == REQUEST) begin
				word_cnt <= '0;
			end else if (word_in) begin
				word_cnt <= word_cnt + 1'b1; // line always starts at word 0
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state_q == IDLE && i_miss) begin
			miss_addr <= i_miss_addr;
			victim_mask <= way_mask_t'(1) << i_victim;
		end
		if (inval_take) begin
			inval_set <= i_inval_addr[OFF_W +: IDX_W];
		end
	end

	assign o_busy = state_q != IDLE;
	assign o_mem_req.valid = state_q == REQUEST;
	assign o_mem_req.line_addr = {miss_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

	// sweep, new tag, or hit-invalidate of all ways
	always_comb begin
		o_tag_wen = '0;
		o_tag_waddr = inval_set;
		o_tag_wvalid = 1'b0;
		o_tag_wtag = miss_addr[ADDR_W-1 -: TAG_W];
		if (state_q == INVALIDATING) begin
			o_tag_wen = '1;
			o_tag_waddr = sweep_cnt;
		end else if (state_q == REFILL) begin
			o_tag_wen = victim_mask;
			o_tag_waddr = miss_set;
			o_tag_wvalid = 1'b1;
		end else if (inval_q) begin
			o_tag_wen = '1;
		end
	end

	assign o_data_wen = word_in ? victim_mask : '0;
	assign o_data_waddr = {miss_set, word_cnt};
	assign o_fwd_valid = word_in && word_cnt == miss_addr[OFF_W-1:0];
	assign o_fwd_data = i_mem_resp.data;

endmodule

/* logic/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup #(
	parameter int LINE_WORDS = 8,
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int TAG_W = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_valid,
	input  icache_pkg::word_t i_addr,
	input  logic i_busy,
	input  icache_pkg::way_mask_t i_rvalid,
	input  logic [icache_pkg::WAYS-1:0][TAG_W-1:0] i_rtags,
	input  icache_pkg::word_t [icache_pkg::WAYS-1:0] i_rdata,
	input  logic i_fwd_valid,
	input  icache_pkg::word_t i_fwd_data,
	output logic [IDX_W+OFF_W-1:0] o_raddr,
	output logic o_hit_touch,
	output icache_pkg::way_idx_t o_hit_way,
	output logic [IDX_W-1:0] o_set,
	output logic o_miss,
	output icache_pkg::word_t o_miss_addr,
	output logic o_valid,
	output icache_pkg::word_t o_data
);
	import icache_pkg::*;

	logic stall;
	logic s1_valid;
	word_t s1_addr;
	logic s2_valid;
	word_t s2_addr;
	way_mask_t hit_mask;
	logic s2_hit;

	assign stall = i_busy || o_miss;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (!stall) begin
				s1_valid <= i_valid;
			end
			s2_valid <= s1_valid && !stall; // a miss is handed to refill
		end
	end

	always_ff @(posedge i_clk) begin
		if (!stall) begin
			s1_addr <= i_addr;
			s2_addr <= s1_addr;
		end
	end

	// stage 1's line is read every cycle, so a held request sees the refilled tags
	assign o_raddr = s1_addr[IDX_W+OFF_W-1:0];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_mask[w] = i_rvalid[w] && i_rtags[w] == s2_addr[ADDR_W-1 -: TAG_W];
		end
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_mask[w]) begin
				o_hit_way = way_idx_t'(w);
			end
		end
	end

	assign s2_hit = s2_valid && |hit_mask;
	assign o_hit_touch = s2_hit;
	assign o_miss = s2_valid && !(|hit_mask);
	assign o_miss_addr = s2_addr;
	assign o_set = s2_addr[OFF_W +: IDX_W];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= s2_hit || i_fwd_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_fwd_valid) begin
			o_data <= i_fwd_data;
		end else if (s2_hit) begin
			o_data <= i_rdata[o_hit_way];
		end
	end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
	parameter int LINE_WORDS = 8,
	parameter int SETS = 64,
	localparam int IDX_W = $clog2(SETS),
	localparam int OFF_W = $clog2(LINE_WORDS),
	localparam int TAG_W = icache_pkg::ADDR_W - IDX_W - OFF_W
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_valid,
	input  icache_pkg::word_t i_addr,
	input  logic i_inval,
	input  icache_pkg::word_t i_inval_addr,
	input  icache_pkg::mem_resp_t i_mem_resp,
	output logic o_valid,
	output icache_pkg::word_t o_data,
	output logic o_stall,
	output icache_pkg::mem_req_t o_mem_req
);
	import icache_pkg::*;

	logic [IDX_W+OFF_W-1:0] raddr;
	way_mask_t rvalid;
	logic [WAYS-1:0][TAG_W-1:0] rtags;
	word_t [WAYS-1:0] rdata;
	way_mask_t tag_wen;
	logic [IDX_W-1:0] tag_waddr;
	logic tag_wvalid;
	logic [TAG_W-1:0] tag_wtag;
	way_mask_t data_wen;
	logic [IDX_W+OFF_W-1:0] data_waddr;
	logic busy;
	logic miss;
	word_t miss_addr;
	logic hit_touch;
	way_idx_t hit_way;
	way_idx_t victim;
	way_idx_t touch_way;
	logic [IDX_W-1:0] lru_set;
	logic fwd_valid;
	word_t fwd_data;

	assign o_stall = busy || miss;
	assign touch_way = miss ? victim : hit_way; // victim counts as used

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_tag_ram #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) u_tag_ram (
			.i_clk    (i_clk),
			.i_rst    (i_rst),
			.i_wen    (tag_wen[w]),
			.i_waddr  (tag_waddr),
			.i_wvalid (tag_wvalid),
			.i_wtag   (tag_wtag),
			.i_raddr  (raddr[IDX_W+OFF_W-1:OFF_W]),
			.o_rvalid (rvalid[w]),
			.o_rtag   (rtags[w])
		);

		icache_data_ram #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) u_data_ram (
			.i_clk   (i_clk),
			.i_wen   (data_wen[w]),
			.i_waddr (data_waddr),
			.i_wdata (i_mem_resp.data),
			.i_raddr (raddr),
			.o_rdata (rdata[w])
		);
	end

	icache_lookup #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) u_lookup (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_valid     (i_valid),
		.i_addr      (i_addr),
		.i_busy      (busy),
		.i_rvalid    (rvalid),
		.i_rtags     (rtags),
		.i_rdata     (rdata),
		.i_fwd_valid (fwd_valid),
		.i_fwd_data  (fwd_data),
		.o_raddr     (raddr),
		.o_hit_touch (hit_touch),
		.o_hit_way   (hit_way),
		.o_set       (lru_set),
		.o_miss      (miss),
		.o_miss_addr (miss_addr),
		.o_valid     (o_valid),
		.o_data      (o_data)
	);

	icache_refill #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) u_refill (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_miss       (miss),
		.i_miss_addr  (miss_addr),
		.i_victim     (victim),
		.i_inval      (i_inval),
		.i_inval_addr (i_inval_addr),
		.i_mem_resp   (i_mem_resp),
		.o_busy       (busy),
		.o_mem_req    (o_mem_req),
		.o_tag_wen    (tag_wen),
		.o_tag_waddr  (tag_waddr),
		.o_tag_wvalid (tag_wvalid),
		.o_tag_wtag   (tag_wtag),
		.o_data_wen   (data_wen),
		.o_data_waddr (data_waddr),
		.o_fwd_valid  (fwd_valid),
		.o_fwd_data   (fwd_data)
	);

	icache_plru #(.SETS(SETS)) u_plru (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_set       (lru_set),
		.i_touch     (hit_touch || miss),
		.i_touch_way (touch_way),
		.o_victim    (victim)
	);

endmodule

/* dv/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model #(
	parameter int LINE_WORDS = 8,
	parameter int SEED = 32'h4d10
) (
	input  logic i_clk,
	input  icache_pkg::mem_req_t i_req,
	output icache_pkg::mem_resp_t o_resp
);
	import icache_pkg::*;

	integer seed;
	logic active;
	word_t base;
	int word_idx;
	int gap;

	// one line per request, word 0 first, gaps of 0 to 3 cycles
	initial begin
		seed = SEED;
		active = 1'b0;
		base = '0;
		word_idx = 0;
		gap = 0;
		o_resp = '0;
		forever begin
			@(negedge i_clk);
			o_resp = '0;
			if (active) begin
				if (gap > 0) begin
					gap--;
				end else begin
					o_resp.valid = 1'b1;
					o_resp.last = word_idx == LINE_WORDS - 1;
					o_resp.data = (base + word_t'(word_idx)) ^ 32'hC0DE_0000;
					word_idx++;
					active = word_idx < LINE_WORDS;
					gap = $random(seed) & 3;
				end
			end
			if (i_req.valid) begin
				active = 1'b1;
				base = i_req.line_addr;
				word_idx = 0;
				gap = $random(seed) & 7; // first word latency
			end
		end
	end

endmodule

/* dv/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
	import icache_pkg::*;

	localparam int LINE_WORDS = 8;
	localparam int SETS = 64;
	localparam int OFF_W = $clog2(LINE_WORDS);
	localparam int IDX_W = $clog2(SETS);
	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic is_inval; // hit-invalidate instead of read
		word_t addr;
		logic miss;     // read expected to fetch from memory
	} row_t;

	logic clk = 1'b0;
	logic rst;
	logic valid;
	word_t addr;
	logic inval;
	word_t inval_addr;
	mem_resp_t mem_resp;
	logic rd_valid;
	word_t rd_data;
	logic stall;
	mem_req_t mem_req;

	row_t rows[$];
	int checks;
	int errors;
	bit hung;

	always #20 clk = ~clk;

	icache_top #(.LINE_WORDS(LINE_WORDS), .SETS(SETS)) dut (
		.i_clk        (clk),
		.i_rst        (rst),
		.i_valid      (valid),
		.i_addr       (addr),
		.i_inval      (inval),
		.i_inval_addr (inval_addr),
		.i_mem_resp   (mem_resp),
		.o_valid      (rd_valid),
		.o_data       (rd_data),
		.o_stall      (stall),
		.o_mem_req    (mem_req)
	);

	icache_mem_model #(.LINE_WORDS(LINE_WORDS), .SEED(32'h4d10)) u_mem (
		.i_clk  (clk),
		.i_req  (mem_req),
		.o_resp (mem_resp)
	);

	function automatic word_t make_addr(int tag, int set, int off);
		return (word_t'(tag) << (IDX_W + OFF_W)) | (word_t'(set) << OFF_W) | word_t'(off);
	endfunction

	// every memory word holds its own address xor C0DE_0000
	function automatic word_t expect_word(word_t a);
		return a ^ 32'hC0DE_0000;
	endfunction

	function automatic word_t line_of(word_t a);
		return a & ~word_t'(LINE_WORDS - 1);
	endfunction

	task automatic check_val(string name, word_t got, word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic add_row(logic is_inval, word_t a, logic miss);
		row_t r;
		r.is_inval = is_inval;
		r.addr = a;
		r.miss = miss;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// cold misses at offsets 0, 5 and 7, then hits
		add_row(1'b0, make_addr(7, 1, 0), 1'b1);
		add_row(1'b0, make_addr(7, 2, 5), 1'b1);
		add_row(1'b0, make_addr(7, 3, 7), 1'b1);
		add_row(1'b0, make_addr(7, 1, 3), 1'b0);
		add_row(1'b0, make_addr(7, 2, 5), 1'b0);
		// A B C D fill set 5, A hit, E evicts B
		add_row(1'b0, make_addr(1, 5, 2), 1'b1);
		add_row(1'b0, make_addr(2, 5, 4), 1'b1);
		add_row(1'b0, make_addr(3, 5, 6), 1'b1);
		add_row(1'b0, make_addr(4, 5, 1), 1'b1);
		add_row(1'b0, make_addr(1, 5, 0), 1'b0);
		add_row(1'b0, make_addr(5, 5, 3), 1'b1);
		add_row(1'b0, make_addr(1, 5, 7), 1'b0);
		add_row(1'b0, make_addr(2, 5, 4), 1'b1);
		// whole set 5 dropped, set 1 untouched
		add_row(1'b1, make_addr(0, 5, 0), 1'b0);
		add_row(1'b0, make_addr(1, 5, 2), 1'b1);
		add_row(1'b0, make_addr(2, 5, 4), 1'b1);
		add_row(1'b0, make_addr(7, 1, 3), 1'b0);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (stall && !hung) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				errors++;
				hung = 1'b1;
				$display("timeout: o_stall stayed high for %0d cycles", TIMEOUT);
			end
		end
	endtask

	task automatic check_sweep();
		int n;
		n = 0;
		@(negedge clk);
		while (stall && !hung) begin
			check_val("o_valid", rd_valid, 1'b0);
			check_val("o_mem_req.valid", mem_req.valid, 1'b0);
			@(negedge clk);
			n++;
			if (n > SETS + 8) begin
				errors++;
				hung = 1'b1;
				$display("timeout: o_stall did not fall after the reset sweep");
			end
		end
	endtask

	task automatic apply_row(row_t r);
		int n;
		int reqs;
		word_t req_line;
		wait_ready();
		if (hung) begin
			return;
		end
		if (r.is_inval) begin
			inval = 1'b1;
			inval_addr = r.addr;
			@(negedge clk);
			inval = 1'b0;
			return;
		end
		valid = 1'b1;
		addr = r.addr;
		@(negedge clk); // accepted on the edge just passed
		valid = 1'b0;
		n = 0;
		reqs = 0;
		req_line = '0;
		while (!rd_valid && !hung) begin
			@(negedge clk);
			n++;
			if (n == 1) begin
				check_val("o_stall", stall, r.miss); // miss known in stage 2
			end
			if (mem_req.valid) begin
				reqs++;
				req_line = mem_req.line_addr;
			end
			if (n > TIMEOUT) begin
				errors++;
				hung = 1'b1;
				$display("timeout: no o_valid for read of address %h", r.addr);
			end
		end
		if (hung) begin
			return;
		end
		check_val("o_data", rd_data, expect_word(r.addr));
		check_val("o_mem_req.valid pulses", reqs, r.miss ? 1 : 0);
		if (r.miss) begin
			check_val("o_mem_req.line_addr", req_line, line_of(r.addr));
		end else begin
			check_val("hit latency", n, 2);
		end
	endtask

	// two hits in consecutive cycles give two consecutive o_valid pulses
	task automatic hit_pair(word_t a0, word_t a1);
		wait_ready();
		if (hung) begin
			return;
		end
		valid = 1'b1;
		addr = a0;
		@(negedge clk);
		addr = a1;
		@(negedge clk);
		valid = 1'b0;
		@(negedge clk);
		check_val("o_valid", rd_valid, 1'b1);
		check_val("o_data", rd_data, expect_word(a0));
		@(negedge clk);
		check_val("o_valid", rd_valid, 1'b1);
		check_val("o_data", rd_data, expect_word(a1));
		@(negedge clk);
		check_val("o_valid", rd_valid, 1'b0);
	endtask

	initial begin
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		inval = 1'b0;
		inval_addr = '0;
		checks = 0;
		errors = 0;
		hung = 1'b0;
		build_table();
		repeat (4) @(negedge clk);
		rst = 1'b0;
		check_sweep();
		foreach (rows[i]) begin
			if (!hung) begin
				apply_row(rows[i]);
			end
		end
		if (!hung) begin
			hit_pair(make_addr(7, 1, 3), make_addr(7, 2, 5));
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* tb.f */
logic/icache_pkg.sv
logic/icache_tag_ram.sv
logic/icache_data_ram.sv
logic/icache_plru.sv
logic/icache_refill.sv
logic/icache_lookup.sv
logic/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv
